// File: h80_alu.sv
`timescale 1ns/10ps

module h80_alu #(
   parameter int reg_width = 16
) (
   input  logic clk,
   input  logic reset,
   input  h80_isa_pkg::alu_op_t op,
   input  logic [reg_width-1:0] a,
   input  logic [reg_width-1:0] b,
   input  logic flag_update,
   output logic [reg_width-1:0] result,
   output h80_isa_pkg::flag_t flags
);

   localparam int sb = reg_width - 1;  // sign bit

   logic [reg_width:0] res;  // extra bit holds carry or borrow
   logic carry;
   logic overflow;

   always_comb begin
      case (op)
         h80_isa_pkg::alu_add: res = {1'b0, a} + {1'b0, b};
         h80_isa_pkg::alu_sub,
         h80_isa_pkg::alu_cp:  res = {1'b0, a} - {1'b0, b};
         h80_isa_pkg::alu_and: res = {1'b0, a & b};
         h80_isa_pkg::alu_or:  res = {1'b0, a | b};
         h80_isa_pkg::alu_xor: res = {1'b0, a ^ b};
         default:              res = '0;
      endcase
   end

   assign result = res[sb:0];

   always_comb begin
      case (op)
         h80_isa_pkg::alu_add: begin
            carry = res[reg_width];
            overflow = (a[sb] == b[sb]) && (res[sb] != a[sb]);  // same signs in
         end
         h80_isa_pkg::alu_sub,
         h80_isa_pkg::alu_cp: begin
            carry = res[reg_width];  // borrow
            overflow = (a[sb] != b[sb]) && (res[sb] != a[sb]);
         end
         default: begin
            carry = 1'b0;
            overflow = ~^res[sb:0];  // even parity for logic ops
         end
      endcase
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         flags <= '0;
      end else if (flag_update) begin
         flags[h80_isa_pkg::flag_sign] <= res[sb];
         flags[h80_isa_pkg::flag_zero] <= (res[sb:0] == '0);
         flags[h80_isa_pkg::flag_carry] <= carry;
         flags[h80_isa_pkg::flag_overflow] <= overflow;
      end
   end

endmodule

// File: h80_bus_pkg.sv
package h80_bus_pkg;

   localparam int bus_addr_width = 16;
   localparam int bus_data_width = 16;

   typedef logic [bus_addr_width-1:0] bus_addr_t;
   typedef logic [bus_data_width-1:0] bus_data_t;

   // memory commands, same encoding as the ccc field of a memory instruction
   typedef enum logic [2:0] {
      bus_cmd_none = 3'd0,
      bus_cmd_read_w = 3'd1,
      bus_cmd_write_w = 3'd2
   } bus_cmd_t;

endpackage

// File: h80_bus_unit.sv
`timescale 1ns/10ps

module h80_bus_unit #(
   parameter int reg_width = 16
) (
   input  logic clk,
   input  logic reset,
   input  logic bus_issue,
   input  h80_bus_pkg::bus_cmd_t bus_cmd,
   input  logic [reg_width-1:0] bus_addr,
   input  logic [reg_width-1:0] bus_wr_data,
   output h80_bus_pkg::bus_cmd_t mem_cmd,
   output h80_bus_pkg::bus_addr_t mem_addr,
   output h80_bus_pkg::bus_data_t mem_wr_data,
   input  h80_bus_pkg::bus_data_t mem_rd_data,
   output logic [reg_width-1:0] load_data
);

   // first fetch comes from address 0 straight out of reset
   always_ff @(posedge clk) begin
      if (reset) begin
         mem_cmd <= h80_bus_pkg::bus_cmd_read_w;
         mem_addr <= '0;
      end else if (bus_issue) begin
         mem_cmd <= bus_cmd;
         mem_addr <= bus_addr[h80_bus_pkg::bus_addr_width-1:0];  // low word of address
      end
   end

   always_ff @(posedge clk) begin
      if (bus_issue) begin
         mem_wr_data <= bus_wr_data[h80_bus_pkg::bus_data_width-1:0];
      end
   end

   assign load_data = reg_width'(mem_rd_data);  // zero-extend bus word

   a_mem_cmd_legal: assert property (
      @(posedge clk) disable iff (reset)
      !$isunknown(mem_cmd) && mem_cmd inside {h80_bus_pkg::bus_cmd_none,
                                             h80_bus_pkg::bus_cmd_read_w,
                                             h80_bus_pkg::bus_cmd_write_w}
   );

endmodule

// File: h80_control.sv
`timescale 1ns/10ps

module h80_control #(
   parameter int reg_width = 16
) (
   input  logic clk,
   input  logic reset,
   input  h80_bus_pkg::bus_data_t mem_rd_data,
   input  logic mem_wait_n,
   input  logic [reg_width-1:0] rd_a,
   input  logic [reg_width-1:0] rd_b,
   input  logic [reg_width-1:0] alu_result,
   input  h80_isa_pkg::flag_t flags,
   input  logic [reg_width-1:0] pc,
   input  logic [reg_width-1:0] next_pc,
   input  logic [reg_width-1:0] load_data,
   output h80_isa_pkg::reg_num_t rd_a_num,
   output h80_isa_pkg::reg_num_t rd_b_num,
   output logic wr_en,
   output h80_isa_pkg::reg_num_t wr_num,
   output logic [reg_width-1:0] wr_data,
   output h80_isa_pkg::alu_op_t alu_op,
   output logic flag_update,
   output logic pc_update,
   output logic pc_jump,
   output logic [reg_width-1:0] pc_target,
   output logic bus_issue,
   output h80_bus_pkg::bus_cmd_t bus_cmd,
   output logic [reg_width-1:0] bus_addr,
   output logic [reg_width-1:0] bus_wr_data,
   output logic halted
);

   typedef enum logic {fetch_exec, bus_rw} state_t;

   state_t state;
   logic load_pend;                    // data access is a load
   h80_isa_pkg::reg_num_t load_num;    // load destination
   h80_isa_pkg::ins_t ins;
   logic done;
   logic is_alu;
   logic is_mem;
   logic mem_go;
   logic halt_go;
   logic [reg_width-1:0] imm_u;
   logic [reg_width-1:0] imm_s;

   assign ins = mem_rd_data;              // fetched word, valid at completion
   assign done = !halted && mem_wait_n;   // an access is always open until halt
   assign imm_u = {{(reg_width-8){1'b0}}, ins[7:0]};
   assign imm_s = {{(reg_width-8){ins[7]}}, ins[7:0]};
   assign is_mem = (ins[15:12] == h80_isa_pkg::op_mem) && !ins[8] &&
                   (ins[11:9] == h80_bus_pkg::bus_cmd_read_w ||
                    ins[11:9] == h80_bus_pkg::bus_cmd_write_w);

   always_comb begin
      is_alu = 1'b1;
      case (ins[15:12])
         h80_isa_pkg::op_alu_add: alu_op = h80_isa_pkg::alu_add;
         h80_isa_pkg::op_alu_sub: alu_op = h80_isa_pkg::alu_sub;
         h80_isa_pkg::op_alu_and: alu_op = h80_isa_pkg::alu_and;
         h80_isa_pkg::op_alu_or:  alu_op = h80_isa_pkg::alu_or;
         h80_isa_pkg::op_alu_xor: alu_op = h80_isa_pkg::alu_xor;
         h80_isa_pkg::op_alu_cp:  alu_op = h80_isa_pkg::alu_cp;
         default: begin
            alu_op = h80_isa_pkg::alu_add;
            is_alu = 1'b0;
         end
      endcase
   end

   always_comb begin
      rd_a_num = ins[7:4];  // alu a, store data, move source
      rd_b_num = ins[3:0];  // alu b, address, jump target
      wr_en = 1'b0;
      wr_num = ins[11:8];
      wr_data = alu_result;
      flag_update = 1'b0;
      pc_update = 1'b0;
      pc_jump = 1'b0;
      pc_target = rd_b;
      bus_issue = done;
      bus_cmd = h80_bus_pkg::bus_cmd_read_w;
      bus_addr = next_pc;
      bus_wr_data = rd_a;
      mem_go = 1'b0;
      halt_go = 1'b0;
      if (state == bus_rw) begin
         bus_addr = pc;  // pc already stepped at execute
         wr_en = done && load_pend;
         wr_num = load_num;
         wr_data = load_data;
      end else begin
         pc_update = done;
         if (ins == h80_isa_pkg::op_nop) begin
            // nothing but the next fetch
         end else if (ins == h80_isa_pkg::op_halt) begin
            halt_go = done;
            bus_cmd = h80_bus_pkg::bus_cmd_none;
         end else if (ins[15:4] == h80_isa_pkg::op_jp_r) begin
            pc_jump = 1'b1;
         end else if (ins[15:6] == h80_isa_pkg::op_jpn_f) begin
            pc_jump = !flags[ins[5:4]];
         end else if (ins[15:6] == h80_isa_pkg::op_jp_f) begin
            pc_jump = flags[ins[5:4]];
         end else if (ins[15:12] == h80_isa_pkg::op_ldi_u) begin
            wr_en = done;
            wr_data = imm_u;
         end else if (ins[15:12] == h80_isa_pkg::op_ldi_s) begin
            wr_en = done;
            wr_data = imm_s;
         end else if (is_mem) begin
            mem_go = done;
            bus_cmd = h80_bus_pkg::bus_cmd_t'(ins[11:9]);
            bus_addr = rd_b;
         end else if (ins[15:8] == h80_isa_pkg::op_move) begin
            wr_en = done;
            wr_num = ins[3:0];
            wr_data = rd_a;
         end else if (is_alu) begin
            flag_update = done;
            wr_en = done && (alu_op != h80_isa_pkg::alu_cp);  // cp only sets flags
         end
      end
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         state <= fetch_exec;
         halted <= 1'b0;
         load_pend <= 1'b0;
      end else if (done) begin
         state <= mem_go ? bus_rw : fetch_exec;
         if (mem_go) begin
            load_pend <= (bus_cmd == h80_bus_pkg::bus_cmd_read_w);
         end
         if (halt_go) begin
            halted <= 1'b1;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (mem_go) begin
         load_num <= ins[7:4];
      end
   end

   // a wait cycle freezes every register in the core
   a_no_issue_in_wait: assert property (
      @(posedge clk) disable iff (reset)
      !mem_wait_n |-> !bus_issue && !wr_en && !flag_update && !pc_update
   );

   // halt is sticky and the core stays idle
   a_halt_quiet: assert property (
      @(posedge clk) disable iff (reset)
      halted |=> halted && !bus_issue && !wr_en && !flag_update && !pc_update
   );

endmodule

// File: h80_cpu.sv
`timescale 1ns/10ps

module h80_cpu #(
   parameter int reg_width = h80_isa_pkg::default_reg_width
) (
   input  logic clk,
   input  logic reset,
   output h80_bus_pkg::bus_cmd_t mem_cmd,
   output h80_bus_pkg::bus_addr_t mem_addr,
   output h80_bus_pkg::bus_data_t mem_wr_data,
   input  h80_bus_pkg::bus_data_t mem_rd_data,
   input  logic mem_wait_n,
   output logic halted
);

   h80_isa_pkg::reg_num_t rd_a_num;
   h80_isa_pkg::reg_num_t rd_b_num;
   h80_isa_pkg::reg_num_t wr_num;
   h80_isa_pkg::alu_op_t alu_op;
   h80_isa_pkg::flag_t flags;
   h80_bus_pkg::bus_cmd_t bus_cmd;
   logic [reg_width-1:0] rd_a;
   logic [reg_width-1:0] rd_b;
   logic [reg_width-1:0] wr_data;
   logic [reg_width-1:0] alu_result;
   logic [reg_width-1:0] pc;
   logic [reg_width-1:0] next_pc;
   logic [reg_width-1:0] pc_target;
   logic [reg_width-1:0] bus_addr;
   logic [reg_width-1:0] bus_wr_data;
   logic [reg_width-1:0] load_data;
   logic wr_en;
   logic flag_update;
   logic pc_update;
   logic pc_jump;
   logic bus_issue;

   h80_control #(.reg_width(reg_width)) h80_control_i (
      .clk(clk), .reset(reset), .mem_rd_data(mem_rd_data), .mem_wait_n(mem_wait_n),
      .rd_a(rd_a), .rd_b(rd_b), .alu_result(alu_result), .flags(flags),
      .pc(pc), .next_pc(next_pc), .load_data(load_data),
      .rd_a_num(rd_a_num), .rd_b_num(rd_b_num),
      .wr_en(wr_en), .wr_num(wr_num), .wr_data(wr_data),
      .alu_op(alu_op), .flag_update(flag_update),
      .pc_update(pc_update), .pc_jump(pc_jump), .pc_target(pc_target),
      .bus_issue(bus_issue), .bus_cmd(bus_cmd), .bus_addr(bus_addr),
      .bus_wr_data(bus_wr_data), .halted(halted)
   );

   h80_regfile #(.reg_width(reg_width)) h80_regfile_i (
      .clk(clk), .reset(reset),
      .rd_a_num(rd_a_num), .rd_a(rd_a), .rd_b_num(rd_b_num), .rd_b(rd_b),
      .wr_en(wr_en), .wr_num(wr_num), .wr_data(wr_data)
   );

   h80_alu #(.reg_width(reg_width)) h80_alu_i (
      .clk(clk), .reset(reset), .op(alu_op), .a(rd_a), .b(rd_b),
      .flag_update(flag_update), .result(alu_result), .flags(flags)
   );

   h80_pc #(.reg_width(reg_width)) h80_pc_i (
      .clk(clk), .reset(reset), .pc_update(pc_update), .pc_jump(pc_jump),
      .pc_target(pc_target), .pc(pc), .next_pc(next_pc)
   );

   h80_bus_unit #(.reg_width(reg_width)) h80_bus_unit_i (
      .clk(clk), .reset(reset), .bus_issue(bus_issue), .bus_cmd(bus_cmd),
      .bus_addr(bus_addr), .bus_wr_data(bus_wr_data),
      .mem_cmd(mem_cmd), .mem_addr(mem_addr), .mem_wr_data(mem_wr_data),
      .mem_rd_data(mem_rd_data), .load_data(load_data)
   );

endmodule

// File: h80_isa_pkg.sv
package h80_isa_pkg;

   localparam int default_reg_width = 16;

   typedef logic [3:0] reg_num_t;   // general register number
   typedef logic [15:0] ins_t;      // one instruction word
   typedef logic [3:0] flag_t;      // s, z, c, v

   // flag bit positions, also the value of an ff field
   localparam int flag_sign = 0;
   localparam int flag_zero = 1;
   localparam int flag_carry = 2;
   localparam int flag_overflow = 3;

   typedef enum logic [2:0] {
      alu_add,
      alu_sub,
      alu_and,
      alu_or,
      alu_xor,
      alu_cp
   } alu_op_t;

   // whole-word opcodes
   localparam ins_t op_nop = 16'h0000;
   localparam ins_t op_halt = 16'h0001;

   // partial fields, compared against the top bits of the word
   localparam logic [11:0] op_jp_r = 12'h01e;           // ins[15:4], rrrr below
   localparam logic [9:0] op_jpn_f = 10'b0000_0011_00;  // ins[15:6], ff rrrr below
   localparam logic [9:0] op_jp_f = 10'b0000_0011_01;   // ins[15:6], ff rrrr below
   localparam logic [7:0] op_move = 8'b0011_1100;       // ins[15:8], aaaa bbbb below

   // top nibble opcodes
   localparam logic [3:0] op_ldi_u = 4'h1;  // dddd nnnnnnnn, zero-extended
   localparam logic [3:0] op_ldi_s = 4'h2;  // dddd nnnnnnnn, sign-extended
   localparam logic [3:0] op_mem = 4'h3;    // ccc 0 aaaa bbbb
   localparam logic [3:0] op_alu_add = 4'h8;
   localparam logic [3:0] op_alu_sub = 4'h9;
   localparam logic [3:0] op_alu_and = 4'hc;
   localparam logic [3:0] op_alu_or = 4'hd;
   localparam logic [3:0] op_alu_xor = 4'he;
   localparam logic [3:0] op_alu_cp = 4'hf;

endpackage

// File: h80_pc.sv
`timescale 1ns/10ps

module h80_pc #(
   parameter int reg_width = 16
) (
   input  logic clk,
   input  logic reset,
   input  logic pc_update,
   input  logic pc_jump,
   input  logic [reg_width-1:0] pc_target,
   output logic [reg_width-1:0] pc,
   output logic [reg_width-1:0] next_pc
);

   // instructions are one word, two bytes apart
   assign next_pc = pc_jump ? pc_target : pc + reg_width'(2);

   always_ff @(posedge clk) begin
      if (reset) begin
         pc <= '0;
      end else if (pc_update) begin
         pc <= next_pc;
      end
   end

endmodule

// File: h80_regfile.sv
`timescale 1ns/10ps

module h80_regfile #(
   parameter int reg_width = 16
) (
   input  logic clk,
   input  logic reset,
   input  h80_isa_pkg::reg_num_t rd_a_num,
   output logic [reg_width-1:0] rd_a,
   input  h80_isa_pkg::reg_num_t rd_b_num,
   output logic [reg_width-1:0] rd_b,
   input  logic wr_en,
   input  h80_isa_pkg::reg_num_t wr_num,
   input  logic [reg_width-1:0] wr_data
);

   logic [reg_width-1:0] regs [16];

   assign rd_a = regs[rd_a_num];  // combinational read ports
   assign rd_b = regs[rd_b_num];

   always_ff @(posedge clk) begin
      if (reset) begin
         for (int i = 0; i < 16; i++) begin
            regs[i] <= '0;
         end
      end else if (wr_en) begin
         regs[wr_num] <= wr_data;
      end
   end

   a_wr_num_known: assert property (
      @(posedge clk) disable iff (reset)
      wr_en |-> !$isunknown(wr_num)
   );

endmodule

// File: src.f
h80_isa_pkg.sv
h80_bus_pkg.sv
h80_regfile.sv
h80_alu.sv
h80_pc.sv
h80_bus_unit.sv
h80_control.sv
h80_cpu.sv
tb_h80_cpu.sv

// File: tb_h80_cpu.sv
`timescale 1ns/10ps

module tb_h80_cpu;

   localparam int ins_per_pass = 160;  // all four programs, counted generously
   localparam int cycle_limit = 64 * ins_per_pass * 2;  // each program runs twice

   logic clk;
   logic reset;
   h80_bus_pkg::bus_cmd_t mem_cmd;
   h80_bus_pkg::bus_addr_t mem_addr;
   h80_bus_pkg::bus_data_t mem_wr_data;
   h80_bus_pkg::bus_data_t mem_rd_data;
   logic mem_wait_n;
   logic halted;

   logic [15:0] mem [32768];  // word addressed, 64 kB
   h80_bus_pkg::bus_addr_t log_addr [$];
   h80_bus_pkg::bus_data_t log_data [$];
   h80_bus_pkg::bus_addr_t exp_addr [$];
   h80_bus_pkg::bus_data_t exp_data [$];
   h80_bus_pkg::bus_cmd_t held_cmd;
   h80_bus_pkg::bus_addr_t held_addr;
   h80_bus_pkg::bus_addr_t after_halt;
   logic hold_active;
   logic use_waits;
   int wait_cnt;
   int accesses;
   int prog_ptr;
   int cycles;
   int checks;
   int errors;
   integer seed;

   h80_cpu h80_cpu_i (
      .clk(clk), .reset(reset), .mem_cmd(mem_cmd), .mem_addr(mem_addr),
      .mem_wr_data(mem_wr_data), .mem_rd_data(mem_rd_data),
      .mem_wait_n(mem_wait_n), .halted(halted)
   );

   always #2 clk = ~clk;

   assign mem_rd_data = mem[mem_addr[15:1]];  // read port of the memory model

   task automatic check_data(input h80_bus_pkg::bus_data_t got,
                             input h80_bus_pkg::bus_data_t exp, input string what);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("CHECK FAILED at %0t: %s, got %h, expected %h", $time, what, got, exp);
      end
   endtask

   task automatic check_addr(input h80_bus_pkg::bus_addr_t got,
                             input h80_bus_pkg::bus_addr_t exp, input string what);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("CHECK FAILED at %0t: %s, got %h, expected %h", $time, what, got, exp);
      end
   endtask

   task automatic check_cmd(input h80_bus_pkg::bus_cmd_t got,
                            input h80_bus_pkg::bus_cmd_t exp, input string what);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("CHECK FAILED at %0t: %s, got %0d, expected %0d", $time, what, got, exp);
      end
   endtask

   task automatic check_bit(input logic got, input logic exp, input string what);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("CHECK FAILED at %0t: %s, got %b, expected %b", $time, what, got, exp);
      end
   endtask

   // memory model: wait states, store log, bus stability
   always @(posedge clk) begin
      int w;
      if (reset) begin
         mem_wait_n <= 1'b1;
         wait_cnt <= 0;
         hold_active <= 1'b0;
      end else begin
         if (hold_active) begin
            check_cmd(mem_cmd, held_cmd, "command changed during wait");
            check_addr(mem_addr, held_addr, "address changed during wait");
         end
         if (mem_cmd != h80_bus_pkg::bus_cmd_none && mem_wait_n) begin
            accesses++;
            if (mem_cmd == h80_bus_pkg::bus_cmd_write_w) begin
               log_addr.push_back(mem_addr);
               log_data.push_back(mem_wr_data);
               mem[mem_addr[15:1]] <= mem_wr_data;
            end else if (mem_addr == after_halt) begin
               errors++;
               $display("word after HALT was fetched at time %0t", $time);
            end
            w = use_waits ? {$random(seed)} % 4 : 0;
            wait_cnt <= w;
            mem_wait_n <= (w == 0);
         end else if (!mem_wait_n) begin
            if (wait_cnt <= 1) begin
               mem_wait_n <= 1'b1;
            end
            wait_cnt <= wait_cnt - 1;
         end
         hold_active <= (mem_cmd != h80_bus_pkg::bus_cmd_none) && !mem_wait_n;
         held_cmd <= mem_cmd;
         held_addr <= mem_addr;
      end
   end

   always @(posedge clk) begin
      cycles++;
      if (cycles >= cycle_limit) begin
         $display("timeout: halted never rose within %0d cycles", cycle_limit);
         $display("Checks failed");
         $finish;
      end
   end

   // ALU reference from the flag rules, 16-bit registers
   function automatic logic [15:0] alu_ref(input logic [3:0] nib, input logic [15:0] a,
                                           input logic [15:0] b,
                                           output h80_isa_pkg::flag_t f);
      logic [16:0] r;
      logic v;
      case (nib)
         4'h8: r = {1'b0, a} + {1'b0, b};
         4'h9, 4'hf: r = {1'b0, a} - {1'b0, b};
         4'hc: r = {1'b0, a & b};
         4'hd: r = {1'b0, a | b};
         default: r = {1'b0, a ^ b};
      endcase
      if (nib == 4'h8) v = (a[15] == b[15]) && (r[15] != a[15]);
      else if (nib == 4'h9 || nib == 4'hf) v = (a[15] != b[15]) && (r[15] != a[15]);
      else v = ~^r[15:0];
      f[h80_isa_pkg::flag_sign] = r[15];
      f[h80_isa_pkg::flag_zero] = (r[15:0] == 16'h0000);
      f[h80_isa_pkg::flag_carry] = (nib == 4'h8 || nib == 4'h9 || nib == 4'hf) ? r[16] : 1'b0;
      f[h80_isa_pkg::flag_overflow] = v;
      return r[15:0];
   endfunction

   task automatic emit(input h80_isa_pkg::ins_t w);
      mem[prog_ptr] = w;
      prog_ptr++;
   endtask

   task automatic new_program();
      for (int i = 0; i < 32768; i++) begin
         mem[i] = i[15:0] ^ 16'h5a3c;  // fill varies with every address bit
      end
      prog_ptr = 0;
      exp_addr.delete();
      exp_data.delete();
   endtask

   // store reg r at 0xff80 + 2k, through r15
   task automatic emit_store(input logic [3:0] r, input int k, input logic [15:0] val,
                             input bit expected);
      logic [7:0] imm;
      imm = 8'h80 + 8'(2 * k);
      emit({4'h2, 4'hf, imm});
      emit({8'h34, r, 4'hf});
      if (expected) begin
         exp_addr.push_back(16'hff80 + 16'(2 * k));
         exp_data.push_back(val);
      end
   endtask

   task automatic emit_halt();
      emit(16'h0001);
      after_halt = 16'(prog_ptr * 2);
      emit(16'h1077);  // must never be fetched
   endtask

   task automatic run_program(input string name, input logic waits);
      int n;
      use_waits = waits;
      log_addr.delete();
      log_data.delete();
      @(posedge clk);
      reset <= 1'b1;
      repeat (3) @(posedge clk);
      @(negedge clk);
      check_cmd(mem_cmd, h80_bus_pkg::bus_cmd_read_w, {name, ": first command"});
      check_addr(mem_addr, 16'h0000, {name, ": first address"});
      check_bit(halted, 1'b0, {name, ": halted after reset"});
      @(posedge clk);
      reset <= 1'b0;
      while (!halted) @(negedge clk);
      checks++;
      if (log_addr.size() != exp_addr.size()) begin
         errors++;
         $display("CHECK FAILED at %0t: %s, %0d stores, expected %0d", $time, name,
                  log_addr.size(), exp_addr.size());
      end else begin
         foreach (exp_addr[i]) begin
            check_addr(log_addr[i], exp_addr[i], {name, ": store address"});
            check_data(log_data[i], exp_data[i], {name, ": store data"});
         end
      end
      n = accesses;
      repeat (8) begin
         @(negedge clk);
         check_cmd(mem_cmd, h80_bus_pkg::bus_cmd_none, {name, ": bus after HALT"});
         check_bit(halted, 1'b1, {name, ": halted stays set"});
      end
      check_data(16'(accesses), 16'(n), {name, ": accesses after HALT"});
   endtask

   task automatic test_immediates();
      new_program();
      emit(16'h1185);  // ldi_u r1
      emit(16'h2285);  // ldi_s r2
      emit(16'h3c13);  // move r1 to r3
      emit_store(4'd1, 0, 16'h0085, 1);
      emit_store(4'd2, 1, 16'hff85, 1);
      emit_store(4'd3, 2, 16'h0085, 1);
      emit_halt();
      run_program("immediates", 0);
      run_program("immediates waits", 1);
   endtask

   task automatic test_alu();
      logic [3:0] nibs [6];
      h80_isa_pkg::flag_t f;
      logic [15:0] val;
      nibs = '{4'h8, 4'h9, 4'hc, 4'hd, 4'he, 4'hf};
      new_program();
      emit(16'h219c);
      emit(16'h1237);
      emit(16'h1811);  // r8 must survive cp
      foreach (nibs[i]) begin
         emit({nibs[i], 4'(3 + i), 8'h12});
      end
      for (int i = 0; i < 6; i++) begin
         val = (i == 5) ? 16'h0011 : alu_ref(nibs[i], 16'hff9c, 16'h0037, f);
         emit_store(4'(3 + i), i, val, 1);
      end
      emit_halt();
      run_program("alu", 0);
      run_program("alu waits", 1);
   endtask

   task automatic test_load();
      new_program();
      mem[16'h0080 >> 1] = 16'hbeef;
      emit(16'h1480);
      emit(16'h3254);  // load r5 from [r4]
      emit_store(4'd5, 0, 16'hbeef, 1);
      emit_halt();
      run_program("load", 0);
      run_program("load waits", 1);
   endtask

   task automatic test_jumps();
      logic [15:0] ops [3][2];
      logic [3:0] alu_nib [3];
      h80_isa_pkg::flag_t f;
      logic [15:0] dummy;
      logic [7:0] target;
      bit taken;
      int k;
      // add overflows, cp equal, cp borrows
      ops = '{'{16'h7f80, 16'h0080}, '{16'h0005, 16'h0005}, '{16'h0003, 16'h0005}};
      alu_nib = '{4'h8, 4'hf, 4'hf};
      new_program();
      k = 0;
      emit(16'h1d5a);  // marker in r13
      for (int c = 0; c < 3; c++) begin
         mem[120 + 2 * c] = ops[c][0];  // operands just past the program
         mem[121 + 2 * c] = ops[c][1];
         emit({4'h1, 4'h3, 8'(240 + 4 * c)});
         emit(16'h3213);  // load r1 from [r3]
         emit({4'h1, 4'h3, 8'(242 + 4 * c)});
         emit(16'h3223);  // load r2 from [r3]
         emit({alu_nib[c], 4'h6, 8'h12});
         dummy = alu_ref(alu_nib[c], ops[c][0], ops[c][1], f);
         for (int fl = 0; fl < 4; fl++) begin
            for (int kind = 0; kind < 2; kind++) begin
               taken = kind ? f[fl] : !f[fl];
               target = 8'((prog_ptr + 4) * 2);
               emit({8'h1e, target});
               emit(16'h0300 | 16'(kind << 6) | 16'(fl << 4) | 16'h000e);
               emit_store(4'd13, k, 16'h005a, !taken);
               k++;
            end
         end
      end
      target = 8'((prog_ptr + 4) * 2);  // unconditional jump over one store
      emit({8'h1e, target});
      emit(16'h01ee);
      emit_store(4'd13, k, 16'h005a, 0);
      emit_store(4'd13, k + 1, 16'h005a, 1);
      emit_halt();
      run_program("jumps", 0);
      run_program("jumps waits", 1);
   endtask

   initial begin
      clk = 1'b0;
      reset = 1'b1;
      mem_wait_n = 1'b1;
      use_waits = 1'b0;
      after_halt = 16'hffff;
      accesses = 0;
      cycles = 0;
      checks = 0;
      errors = 0;
      seed = 32'h7ebe;
      test_immediates();
      test_alu();
      test_load();
      test_jumps();
      $display("%0d checks, %0d errors", checks, errors);
      if (errors == 0) begin
         $display("All checks passed");
      end else begin
         $display("Checks failed");
      end
      $finish;
   end

endmodule
